/* files.f */
+incdir+.
txProgramPkg.sv
txSeqPkg.sv
txStepDecode.sv
txLoopTable.sv
txSequencer.sv
txOutputStage.sv
txController.sv
txControllerTb.sv

/* runSim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module txControllerTb \
	-f files.f -o simTx \
	&& ./obj_dir/simTx | tee /dev/stderr | grep -x "test passed" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

/* txController.sv */
`timescale 1ns/1ps
`default_nettype none

module txController
#(
	parameter int loopDepth = 16
)
(
	input  wire                            txCLK,
	input  wire                            arstN,
	input  wire                            run,
	input  wire                            extTrig,
	input  wire txProgramPkg::channelMaskT userChannelMask,
	input  wire                            adcTriggerAck,
	input  wire txProgramPkg::ctrlWordT    outputControlReg,
	input  wire txProgramPkg::stepTimeT    timingReg,
	input  wire [31:0]                     loopAddressReg,
	input  wire [31:0]                     loopCounterReg,
	output txProgramPkg::progAddrT         readAddr,
	output txProgramPkg::loopIdxT          loopReadAddr,
	output txSeqPkg::txOutT                txOut
);

	txProgramPkg::stepT step;
	txSeqPkg::seqStateT state;
	logic               loadLoops;
	logic               takeWord;
	logic               advance;
	logic               stepStart;

	txStepDecode txStepDecode_i
	(
		.txCLK            (txCLK),
		.arstN            (arstN),
		.takeWord         (takeWord),
		.outputControlReg (outputControlReg),
		.timingReg        (timingReg),
		.step             (step)
	);

	txLoopTable #(.loopDepth(loopDepth)) txLoopTable_i
	(
		.txCLK          (txCLK),
		.arstN          (arstN),
		.loadLoops      (loadLoops),
		.advance        (advance),
		.loopEnd        (step.flags.loopEnd),  // flag of the word now ending
		.loopAddressReg (loopAddressReg),
		.loopCounterReg (loopCounterReg),
		.readAddr       (readAddr),
		.loopReadAddr   (loopReadAddr)
	);

	txSequencer #(.loopDepth(loopDepth)) txSequencer_i
	(
		.txCLK     (txCLK),
		.arstN     (arstN),
		.run       (run),
		.extTrig   (extTrig),
		.step      (step),
		.loadLoops (loadLoops),
		.takeWord  (takeWord),
		.advance   (advance),
		.state     (state),
		.stepStart (stepStart)
	);

	txOutputStage txOutputStage_i
	(
		.txCLK           (txCLK),
		.arstN           (arstN),
		.step            (step),
		.state           (state),
		.stepStart       (stepStart),
		.advance         (advance),
		.userChannelMask (userChannelMask),
		.adcTriggerAck   (adcTriggerAck),
		.out             (txOut)
	);

endmodule

`default_nettype wire

/* txControllerTbProgram.svh */
`ifndef TX_CONTROLLER_TB_PROGRAM_SVH
`define TX_CONTROLLER_TB_PROGRAM_SVH

// program words are {control byte, trigger byte, LED pins, transducer pins}
localparam int progLen = 8;
localparam txProgramPkg::ctrlWordT progWords [progLen] = '{
	32'h0000_01A5, 32'h0077_025A, 32'h1000_03C3, 32'h0000_043C,
	32'h2000_05F0, 32'h0200_060F, 32'h0800_0799, 32'h8000_0866
};
localparam txProgramPkg::stepTimeT progTimes [progLen] = '{
	32'd2, 32'd1, 32'd0, 32'd2, 32'd1, 32'd2, 32'd3, 32'd4
};

// readAddr points one word past the running step, so word 2 carries loopEnd for endAddr 3
localparam int          loopSlot      = 5;
localparam logic [31:0] loopAddrWord  = {16'd3, 16'd2};  // endAddr high, startAddr low
localparam logic [31:0] loopCountWord = 32'd3;

// word 0 is latched at load and again at the end of its first run, so it shows twice
localparam int stepCount = 13;
localparam stepEntryT stepTable [stepCount] = '{
	'{16'h01A5, 32'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{16'h01A5, 32'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{16'h025A, 32'd1, 1'b0, 1'b0, 1'b0, 1'b0},
	'{16'h03C3, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0},  // loop body, first pass
	'{16'h043C, 32'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{16'h03C3, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0},  // second pass
	'{16'h043C, 32'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{16'h03C3, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0},  // third pass
	'{16'h043C, 32'd2, 1'b0, 1'b0, 1'b0, 1'b0},
	'{16'h05F0, 32'd1, 1'b0, 1'b0, 1'b0, 1'b1},  // waits for extTrig afterwards
	'{16'h060F, 32'd2, 1'b1, 1'b0, 1'b0, 1'b0},
	'{16'h0799, 32'd3, 1'b0, 1'b1, 1'b0, 1'b0},
	'{16'h0866, 32'd4, 1'b0, 1'b0, 1'b1, 1'b0}   // finished word
};

`endif

/* txControllerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module txControllerTb;

	localparam int loopDepth = 16;
	localparam int progDepth = 64;
	localparam int waitLimit = 100;  // longest any single wait may take, in cycles

	typedef struct packed
	{
		txProgramPkg::pinWordT  pins;       // word pins before the channel mask
		txProgramPkg::stepTimeT duration;
		logic                   adcSet;     // step raises adcTrig as it ends
		logic                   dmaPulse;
		logic                   ackDrive;   // adcTriggerAck pulsed at the start of this step
		logic                   waitsTrig;
	} stepEntryT;

	`include "txControllerTbProgram.svh"

	logic                      txCLK;
	logic                      arstN;
	logic                      run;
	logic                      extTrig;
	txProgramPkg::channelMaskT userChannelMask;
	logic                      adcTriggerAck;
	txProgramPkg::ctrlWordT    outputControlReg;
	txProgramPkg::stepTimeT    timingReg;
	logic [31:0]               loopAddressReg;
	logic [31:0]               loopCounterReg;
	txProgramPkg::progAddrT    readAddr;
	txProgramPkg::loopIdxT     loopReadAddr;
	txSeqPkg::txOutT           txOut;

	txProgramPkg::ctrlWordT progMem [progDepth];
	txProgramPkg::stepTimeT timeMem [progDepth];
	logic [31:0]            loopAddrMem [loopDepth];
	logic [31:0]            loopCountMem [loopDepth];
	logic [31:0]            lfsr;
	logic                   adcExp;  // level adcTrig should have now
	int                     loadCycles;
	stepEntryT              entry;
	txProgramPkg::pinWordT  expPins;

	// both memories answer in the same cycle as the address
	assign outputControlReg = progMem[readAddr[5:0]];
	assign timingReg        = timeMem[readAddr[5:0]];
	assign loopAddressReg   = loopAddrMem[loopReadAddr];
	assign loopCounterReg   = loopCountMem[loopReadAddr];

	txController #(.loopDepth(loopDepth)) txController_i
	(
		.txCLK            (txCLK),
		.arstN            (arstN),
		.run              (run),
		.extTrig          (extTrig),
		.userChannelMask  (userChannelMask),
		.adcTriggerAck    (adcTriggerAck),
		.outputControlReg (outputControlReg),
		.timingReg        (timingReg),
		.loopAddressReg   (loopAddressReg),
		.loopCounterReg   (loopCounterReg),
		.readAddr         (readAddr),
		.loopReadAddr     (loopReadAddr),
		.txOut            (txOut)
	);

	always
	begin
		#4 txCLK = ~txCLK;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2 and 1
	endfunction

	task automatic reportError(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		$display("test failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic abortOnTimeout(input string what);
		$display("timed out waiting for %s", what);
		$display("test failed");
		$fatal(1, "wait limit exceeded");
	endtask

	task automatic checkPins(input txProgramPkg::pinWordT actual,
		input txProgramPkg::pinWordT expected, input string what);
		if (actual !== expected)
		begin
			reportError($sformatf("%s: pins %h, expected %h", what, actual, expected));
		end
	endtask

	task automatic checkState(input logic [7:0] leds, input txSeqPkg::seqStateT expected,
		input string what);
		if (leds !== 8'(expected))
		begin
			reportError($sformatf("%s: LEDs %h, expected %s", what, leds, expected.name()));
		end
	endtask

	task automatic checkFlag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
		begin
			reportError($sformatf("%s: got %b, expected %b", what, actual, expected));
		end
	endtask

	task automatic awaitLedCode(input txSeqPkg::seqStateT code, input string what);
		int n;
		n = 0;
		@(negedge txCLK);
		while (txOut.leds !== 8'(code))
		begin
			checkPins(txOut.pins, '0, what);  // nothing drives the pins before the first step
			n++;
			if (n > waitLimit)
			begin
				abortOnTimeout(what);
			end
			@(negedge txCLK);
		end
	endtask

	task automatic syncToPins(input txProgramPkg::pinWordT expected, input string what);
		int n;
		n = 0;
		@(negedge txCLK);
		while (txOut.pins !== expected)
		begin
			n++;
			if (n > waitLimit)
			begin
				abortOnTimeout(what);
			end
			@(negedge txCLK);
		end
	endtask

	initial
	begin
		txCLK         = 1'b0;
		arstN         = 1'b0;
		run           = 1'b0;
		extTrig       = 1'b0;
		adcTriggerAck = 1'b0;
		adcExp        = 1'b0;
		lfsr          = 32'h26d41e9d;
		for (int b = 0; b < 8; b++)
		begin
			lfsr               = lfsrNext(lfsr);
			userChannelMask[b] = lfsr[0];
		end
		for (int a = 0; a < progDepth; a++)
		begin
			progMem[a] = {8'h80, 8'h00, 8'hEE, 8'(a)};  // stray fetches land on finished words
			timeMem[a] = 32'(a);
		end
		for (int a = 0; a < progLen; a++)
		begin
			progMem[a] = progWords[a];
			timeMem[a] = progTimes[a];
		end
		for (int k = 0; k < loopDepth; k++)
		begin
			loopAddrMem[k]  = {16'hFF00 | 16'(k), 16'(k)};  // end addresses never reached
			loopCountMem[k] = 32'(k + 1);
		end
		loopAddrMem[loopSlot]  = loopAddrWord;
		loopCountMem[loopSlot] = loopCountWord;

		repeat (3) @(negedge txCLK);
		arstN = 1'b1;
		repeat (4)
		begin
			@(negedge txCLK);
			checkState(txOut.leds, txSeqPkg::seqIdle, "idle after reset");
			checkPins(txOut.pins, '0, "idle after reset");
			checkFlag(txOut.adcTrig, 1'b0, "adcTrig after reset");
			checkFlag(txOut.dmaReq, 1'b0, "dmaReq after reset");
			checkFlag(readAddr === 16'h0000, 1'b1, "readAddr at 0 after reset");
			checkFlag(loopReadAddr === 4'h0, 1'b1, "loopReadAddr at 0 after reset");
		end

		run = 1'b1;
		awaitLedCode(txSeqPkg::seqLoadLoops, "start of loop loading");
		loadCycles = 1;
		@(negedge txCLK);
		while (txOut.leds === 8'(txSeqPkg::seqLoadLoops))
		begin
			checkPins(txOut.pins, '0, "loop loading");
			loadCycles++;
			if (loadCycles > waitLimit)
			begin
				abortOnTimeout("end of loop loading");
			end
			@(negedge txCLK);
		end
		checkFlag(loadCycles == loopDepth, 1'b1, "loop loading length");
		repeat (6)
		begin
			checkState(txOut.leds, txSeqPkg::seqWaitTrig, "waiting for start");
			checkPins(txOut.pins, '0, "waiting for start");
			checkFlag(readAddr === 16'h0000, 1'b1, "readAddr at 0 before the first step");
			checkFlag(loopReadAddr === 4'h0, 1'b1, "loopReadAddr back at 0 after loading");
			@(negedge txCLK);
		end

		for (int i = 0; i < stepCount; i++)
		begin
			entry   = stepTable[i];
			expPins = {entry.pins[15:8], entry.pins[7:0] & userChannelMask};
			if (i == 0 || stepTable[i - 1].waitsTrig)
			begin
				extTrig = 1'b1;
				@(negedge txCLK);
				extTrig = 1'b0;
				syncToPins(expPins, $sformatf("pins of step %0d", i));
			end
			else
			begin
				@(negedge txCLK);
			end
			for (int c = 0; c <= int'(entry.duration); c++)
			begin
				if (c > 0)
				begin
					@(negedge txCLK);
				end
				if (c == int'(entry.duration) && entry.adcSet)
				begin
					adcExp = 1'b1;
				end
				if (c == 1 && entry.ackDrive)
				begin
					adcExp = 1'b0;
				end
				checkPins(txOut.pins, expPins, $sformatf("step %0d cycle %0d", i, c));
				checkState(txOut.leds, txSeqPkg::seqRunning, "running step");
				checkFlag(txOut.adcTrig, adcExp, "adcTrig");
				checkFlag(txOut.dmaReq, c == int'(entry.duration) && entry.dmaPulse, "dmaReq");
				adcTriggerAck = (c == 0) && entry.ackDrive;
			end
			if (entry.waitsTrig)
			begin
				repeat (8)
				begin
					@(negedge txCLK);
					checkPins(txOut.pins, expPins, "pins frozen while waiting");
					checkState(txOut.leds, txSeqPkg::seqWaitTrig, "waiting in the program");
					checkFlag(txOut.dmaReq, 1'b0, "dmaReq while waiting");
				end
			end
		end

		repeat (50)
		begin
			@(negedge txCLK);
			checkPins(txOut.pins, '0, "parked after finish");
			checkState(txOut.leds, txSeqPkg::seqDone, "parked after finish");
			checkFlag(txOut.adcTrig, 1'b0, "adcTrig after finish");
			checkFlag(txOut.dmaReq, 1'b0, "dmaReq after finish");
		end
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* txLoopTable.sv */
`timescale 1ns/1ps
`default_nettype none

module txLoopTable
#(
	parameter int loopDepth = 16
)
(
	input  wire                         txCLK,
	input  wire                         arstN,
	input  wire                         loadLoops,
	input  wire                         advance,
	input  wire                         loopEnd,
	input  wire [31:0]                  loopAddressReg,
	input  wire [31:0]                  loopCounterReg,
	output txProgramPkg::progAddrT      readAddr,
	output txProgramPkg::loopIdxT       loopReadAddr
);

	localparam txProgramPkg::loopIdxT lastIdx = txProgramPkg::loopIdxT'(loopDepth - 1);

	txProgramPkg::loopDescT  desc [loopDepth];
	txProgramPkg::loopCountT remCount [loopDepth];  // passes left in each loop
	txProgramPkg::loopDescT  newDesc;
	txProgramPkg::loopIdxT   hitIdx;
	logic                    hit;
	logic                    loopHit;
	logic                    repeatLoop;

	assign newDesc.startAddr = loopAddressReg[15:0];
	assign newDesc.endAddr   = loopAddressReg[31:16];
	assign newDesc.count     = loopCounterReg[15:0];

	// lowest index wins when several loops end on the same word
	always_comb
	begin
		hit    = 1'b0;
		hitIdx = '0;
		for (int k = loopDepth - 1; k >= 0; k--)
		begin
			if (desc[k].endAddr == readAddr)
			begin
				hit    = 1'b1;
				hitIdx = txProgramPkg::loopIdxT'(k);
			end
		end
	end

	assign loopHit    = advance && loopEnd && hit;
	assign repeatLoop = loopHit && (remCount[hitIdx] > 16'd1);

	always_ff @(posedge txCLK)
	begin
		if (loadLoops)
		begin
			desc[loopReadAddr]     <= newDesc;
			remCount[loopReadAddr] <= newDesc.count;
		end
		else if (repeatLoop)
		begin
			remCount[hitIdx] <= remCount[hitIdx] - 1'b1;
		end
		else if (loopHit)
		begin
			remCount[hitIdx] <= desc[hitIdx].count;  // ready for the next time round
		end
	end

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			readAddr     <= '0;
			loopReadAddr <= '0;
		end
		else
		begin
			if (loadLoops)
			begin
				loopReadAddr <= (loopReadAddr == lastIdx) ? '0 : loopReadAddr + 1'b1;
			end
			if (advance)
			begin
				readAddr <= repeatLoop ? desc[hitIdx].startAddr : readAddr + 1'b1;
			end
		end
	end

	// descriptors are only written before the program starts stepping
	assert property (@(posedge txCLK) disable iff (!arstN) advance |-> !loadLoops)
		else $error("advance while the loop table is loading");

endmodule

`default_nettype wire

/* txOutputStage.sv */
`timescale 1ns/1ps
`default_nettype none

module txOutputStage
(
	input  wire                        txCLK,
	input  wire                        arstN,
	input  wire txProgramPkg::stepT    step,
	input  wire txSeqPkg::seqStateT    state,
	input  wire                        stepStart,
	input  wire                        advance,
	input  wire txProgramPkg::channelMaskT userChannelMask,
	input  wire                        adcTriggerAck,
	output txSeqPkg::txOutT            out
);

	txProgramPkg::pinWordT maskedPins;

	assign maskedPins = {step.pins[15:8], step.pins[7:0] & userChannelMask};

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			out <= '0;
		end
		else
		begin
			if (state == txSeqPkg::seqDone)
			begin
				out.pins <= '0;  // finished program parks every pin low
			end
			else if (stepStart)
			begin
				out.pins <= maskedPins;
			end

			// a fresh request wins over an acknowledge in the same cycle
			if (advance && step.flags.beginAcq)
			begin
				out.adcTrig <= 1'b1;
			end
			else if (adcTriggerAck)
			begin
				out.adcTrig <= 1'b0;
			end

			out.dmaReq <= advance && step.flags.dmaRequest;
			out.leds   <= 8'(state);
		end
	end

	// two back to back zero length steps with a DMA request would break this
	assert property (@(posedge txCLK) disable iff (!arstN) out.dmaReq |=> !out.dmaReq)
		else $error("dmaReq held for more than one cycle");

endmodule

`default_nettype wire

/* txProgramPkg.sv */
`default_nettype none

package txProgramPkg;

	typedef logic [15:0] progAddrT;  // program memory address
	typedef logic [3:0]  loopIdxT;   // loop memory index
	typedef logic [31:0] stepTimeT;  // step length in cycles minus one
	typedef logic [31:0] ctrlWordT;  // raw output control word
	typedef logic [15:0] pinWordT;   // low byte transducers, high byte LEDs
	typedef logic [7:0]  channelMaskT;
	typedef logic [15:0] loopCountT;

	// control byte positions inside a program word
	localparam int finishedBit     = 31;
	localparam int armInterruptBit = 30;
	localparam int waitTrigBit     = 29;
	localparam int loopEndBit      = 28;
	localparam int dmaRequestBit   = 27;
	localparam int dmaStartBit     = 26;
	localparam int beginAcqBit     = 25;
	localparam int activeBit       = 24;

	typedef struct packed
	{
		logic finished;      // park outputs and stop
		logic armInterrupt;  // not acted upon
		logic waitTrig;      // hold until extTrig before the next word
		logic loopEnd;       // word may close a loop
		logic dmaRequest;
		logic dmaStart;      // not acted upon
		logic beginAcq;      // raise the ADC trigger line
		logic active;        // not acted upon
	} ctrlFlagsT;

	typedef struct packed
	{
		ctrlFlagsT flags;
		pinWordT   pins;
		stepTimeT  duration;
	} stepT;

	typedef struct packed
	{
		progAddrT  startAddr;
		progAddrT  endAddr;
		loopCountT count;  // reference count, body runs this many times
	} loopDescT;

endpackage

`default_nettype wire

/* txSeqPkg.sv */
`default_nettype none

package txSeqPkg;

	// codes match what the LEDs show
	typedef enum logic [3:0]
	{
		seqIdle      = 4'd0,
		seqWaitTrig  = 4'd1,
		seqRunning   = 4'd2,
		seqLoadLoops = 4'd6,
		seqDone      = 4'd15
	} seqStateT;

	typedef struct packed
	{
		txProgramPkg::pinWordT pins;
		logic                  adcTrig;  // held until acknowledged
		logic                  dmaReq;   // one cycle strobe
		logic [7:0]            leds;     // status code of the sequencer
	} txOutT;

endpackage

`default_nettype wire

/* txSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module txSequencer
#(
	parameter int loopDepth = 16
)
(
	input  wire                     txCLK,
	input  wire                     arstN,
	input  wire                     run,
	input  wire                     extTrig,
	input  wire txProgramPkg::stepT step,
	output logic                    loadLoops,
	output logic                    takeWord,
	output logic                    advance,
	output txSeqPkg::seqStateT      state,
	output logic                    stepStart
);

	localparam txProgramPkg::loopIdxT lastLoad = txProgramPkg::loopIdxT'(loopDepth - 1);

	txProgramPkg::stepTimeT stepCnt;
	txProgramPkg::loopIdxT  loadCnt;
	logic                   loadDone;
	logic                   stepEnd;

	assign loadLoops = (state == txSeqPkg::seqLoadLoops);
	assign loadDone  = loadLoops && (loadCnt == lastLoad);
	assign stepEnd   = (state == txSeqPkg::seqRunning) && (stepCnt == step.duration);
	assign stepStart = (state == txSeqPkg::seqRunning) && (stepCnt == '0);
	assign advance   = stepEnd;
	assign takeWord  = loadDone || stepEnd;  // first word comes in with the last descriptor

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= txSeqPkg::seqIdle;
			stepCnt <= '0;
			loadCnt <= '0;
		end
		else
		begin
			case (state)
				txSeqPkg::seqIdle:
				begin
					loadCnt <= '0;
					if (run)
					begin
						state <= txSeqPkg::seqLoadLoops;
					end
				end
				txSeqPkg::seqLoadLoops:
				begin
					loadCnt <= loadCnt + 1'b1;
					if (loadDone)
					begin
						state <= txSeqPkg::seqWaitTrig;
					end
				end
				txSeqPkg::seqWaitTrig:
				begin
					stepCnt <= '0;
					if (extTrig)
					begin
						state <= txSeqPkg::seqRunning;
					end
				end
				txSeqPkg::seqRunning:
				begin
					if (stepEnd)
					begin
						stepCnt <= '0;
						// flags of the word that is ending decide what follows
						if (step.flags.finished)
						begin
							state <= txSeqPkg::seqDone;
						end
						else if (step.flags.waitTrig)
						begin
							state <= txSeqPkg::seqWaitTrig;
						end
					end
					else
					begin
						stepCnt <= stepCnt + 1'b1;
					end
				end
				txSeqPkg::seqDone:
				begin
					stepCnt <= '0;  // parked until reset
				end
				default:
				begin
					state <= txSeqPkg::seqDone;
				end
			endcase
		end
	end

	// the decoded word only changes at a step boundary, so the counter never passes its duration
	assert property (@(posedge txCLK) disable iff (!arstN)
		state == txSeqPkg::seqRunning |-> stepCnt <= step.duration)
		else $error("step counter ran past the step duration");

endmodule

`default_nettype wire

/* txStepDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module txStepDecode
(
	input  wire                     txCLK,
	input  wire                     arstN,
	input  wire                     takeWord,
	input  wire txProgramPkg::ctrlWordT outputControlReg,
	input  wire txProgramPkg::stepTimeT timingReg,
	output txProgramPkg::stepT      step
);

	txProgramPkg::ctrlWordT wordBuf;
	txProgramPkg::stepTimeT timeBuf;

	always_ff @(posedge txCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			wordBuf <= '0;
			timeBuf <= '0;
		end
		else if (takeWord)
		begin
			wordBuf <= outputControlReg;  // both halves come from the same address
			timeBuf <= timingReg;
		end
	end

	always_comb
	begin
		step.flags.finished     = wordBuf[txProgramPkg::finishedBit];
		step.flags.armInterrupt = wordBuf[txProgramPkg::armInterruptBit];
		step.flags.waitTrig     = wordBuf[txProgramPkg::waitTrigBit];
		step.flags.loopEnd      = wordBuf[txProgramPkg::loopEndBit];
		step.flags.dmaRequest   = wordBuf[txProgramPkg::dmaRequestBit];
		step.flags.dmaStart     = wordBuf[txProgramPkg::dmaStartBit];
		step.flags.beginAcq     = wordBuf[txProgramPkg::beginAcqBit];
		step.flags.active       = wordBuf[txProgramPkg::activeBit];
		step.pins               = wordBuf[15:0];  // trigger byte is not used
		step.duration           = timeBuf;
	end

	// the sequencer must stay quiet for as long as reset is applied
	assert property (@(posedge txCLK) !arstN |-> !takeWord)
		else $error("takeWord raised during reset");

endmodule

`default_nettype wire
